// ==== rtl/ps2_config.svh ====
`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// System clock of the board in Hz
`define PS2_CLK_FREQ 50000000

// Cycles a synchronized PS/2 level must hold before the debounced line follows it
`define PS2_DEBOUNCE_CYCLES 16
`define PS2_DEBOUNCE_W 5 // Wide enough for PS2_DEBOUNCE_CYCLES

// PS/2 clock high this long with a partial frame means the keyboard gave up
// Roughly 55.5 us at 50 MHz and beyond any legal half period of the PS/2 clock
`define PS2_IDLE_CYCLES 2778
`define PS2_IDLE_W 12 // Holds up to 4095

`endif

// ==== rtl/ps2_frame_pkg.sv ====
`default_nettype none

// Wire-level view of one PS/2 device-to-host frame
package ps2_frame_pkg;

	// Full frame as shifted in with the start bit at [0] and the stop bit at [10]
	typedef logic [10:0] ps2_frame_t;

	// Payload byte from bits [8:1] of the frame
	typedef logic [7:0] ps2_byte_t;

	// Frame bits received so far, from 0 up to 11
	typedef logic [3:0] ps2_bit_idx_t;

	// Start + 8 data + parity + stop
	localparam ps2_bit_idx_t FRAME_BITS = 4'd11;

endpackage

`default_nettype wire

// ==== rtl/key_event_pkg.sv ====
`default_nettype none

// Decoded keyboard events, independent of the wire format
package key_event_pkg;

	// Scan code with the E0/F0 prefixes stripped off
	typedef logic [7:0] scan_code_t;

	// One 10-bit key event
	typedef struct packed {
		scan_code_t code; // Base scan code
		logic extended;   // E0 came before the code
		logic released;   // F0 came before the code and the key went up
	} key_event_t;

	// Prefix bytes of scan code set 2
	localparam scan_code_t SC_EXTENDED = 8'hE0;
	localparam scan_code_t SC_BREAK = 8'hF0;

endpackage

`default_nettype wire

// ==== rtl/ps2_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_config.svh"

module ps2_debounce (
	input  logic clk,
	input  logic rst,
	input  logic line_in,  // Raw asynchronous PS/2 pin
	output logic line_out  // Clean level in the clk domain
);

	typedef logic [`PS2_DEBOUNCE_W-1:0] deb_cnt_t;

	localparam deb_cnt_t DEB_LIMIT = deb_cnt_t'(`PS2_DEBOUNCE_CYCLES);

	logic [1:0] sync_q; // [1] is the synchronized value
	deb_cnt_t cnt;      // Cycles the new level has held so far

	// Two-flop synchronizer that idles high like the bus
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], line_in};
		end
	end

	// Stability counter
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			line_out <= 1'b1; // Released bus reads high
		end else if (sync_q[1] == line_out) begin
			cnt <= '0; // Glitch gone or level already taken
		end else if (cnt == DEB_LIMIT) begin
			line_out <= sync_q[1]; // Held long enough
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// A new output level must have stood at the synchronizer for the whole window
	a_stable_window: assert property (@(posedge clk) disable iff (rst)
		$changed(line_out) |-> ($past(sync_q[1]) == line_out)
			&& ($past(sync_q[1], `PS2_DEBOUNCE_CYCLES + 1) == line_out));

endmodule

`default_nettype wire

// ==== rtl/ps2_frame_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_config.svh"

module ps2_frame_rx import ps2_frame_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      line_clk,   // Debounced PS/2 clock
	input  logic      line_data,  // Debounced PS/2 data
	output ps2_byte_t rx_byte,    // Valid with rx_strobe only
	output logic      rx_strobe,  // Good frame
	output logic      rx_error    // Bad or dropped frame
);

	typedef logic [`PS2_IDLE_W-1:0] idle_cnt_t;

	localparam idle_cnt_t IDLE_LIMIT = idle_cnt_t'(`PS2_IDLE_CYCLES);

	logic clk_prev;         // line_clk one cycle back
	logic fall;             // Falling edge of the PS/2 clock
	ps2_frame_t frame_q;    // Shift register that fills from the top
	ps2_bit_idx_t bit_cnt;  // Bits captured in this frame
	idle_cnt_t idle_cnt;    // Cycles of PS/2 clock high
	logic frame_done;
	logic frame_ok;
	logic idle_abort;

	assign fall = clk_prev & ~line_clk;

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_prev <= 1'b1;
		end else begin
			clk_prev <= line_clk;
		end
	end

	// Device drives data on the rising edge, so it is stable at the falling one
	always_ff @(posedge clk) begin
		if (fall) begin
			frame_q <= {line_data, frame_q[10:1]};
		end
	end

	// Bit counter that clears after a full frame or an abort
	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
		end else if (frame_done || idle_abort) begin
			bit_cnt <= '0;
		end else if (fall) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Idle timer that only runs while the PS/2 clock sits high
	always_ff @(posedge clk) begin
		if (rst) begin
			idle_cnt <= '0;
		end else if (!line_clk) begin
			idle_cnt <= '0; // Covers every falling edge
		end else if (idle_cnt != IDLE_LIMIT) begin
			idle_cnt <= idle_cnt + 1'b1; // Saturates at the limit
		end
	end

	assign frame_done = (bit_cnt == FRAME_BITS);

	// Start low, stop high, data plus parity odd
	assign frame_ok = ~frame_q[0] & frame_q[10] & (^frame_q[9:1]);

	// Keyboard stalled mid-frame; an empty receiver just waits
	assign idle_abort = (idle_cnt == IDLE_LIMIT) && (bit_cnt != '0) && !frame_done;

	assign rx_byte = frame_q[8:1];
	assign rx_strobe = frame_done & frame_ok;
	assign rx_error = (frame_done & ~frame_ok) | idle_abort;

	// Results are exclusive one-cycle pulses since the bit count restarts after them
	a_pulse_excl: assert property (@(posedge clk) disable iff (rst)
		(rx_strobe || rx_error) |-> !(rx_strobe && rx_error) ##1 (!rx_strobe && !rx_error));

	// A twelfth edge would mean the frame end was missed
	a_bit_range: assert property (@(posedge clk) disable iff (rst)
		bit_cnt <= FRAME_BITS);

endmodule

`default_nettype wire

// ==== rtl/ps2_scan_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_scan_decoder import ps2_frame_pkg::*, key_event_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  ps2_byte_t  rx_byte,
	input  logic       rx_strobe,
	input  logic       rx_error,
	output key_event_t key_event,
	output logic       key_valid  // One-cycle pulse that qualifies key_event
);

	// Prefixes seen since the last emitted event
	typedef enum logic [1:0] {
		IDLE,
		GOT_E0,
		GOT_F0,
		GOT_E0_F0
	} dec_state_t;

	dec_state_t state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			key_valid <= 1'b0;
		end else begin
			key_valid <= 1'b0; // Pulse only by default
			if (rx_error) begin
				state <= IDLE; // Drop any half-seen prefix
			end else if (rx_strobe) begin
				if (rx_byte == SC_EXTENDED) begin
					state <= GOT_E0;
				end else if (rx_byte == SC_BREAK) begin
					// Extended release keeps the E0 flag
					if (state == GOT_E0 || state == GOT_E0_F0) begin
						state <= GOT_E0_F0;
					end else begin
						state <= GOT_F0;
					end
				end else begin
					key_valid <= 1'b1;
					state <= IDLE;
				end
			end
		end
	end

	// Event payload qualified by key_valid
	always_ff @(posedge clk) begin
		if (rx_strobe && rx_byte != SC_EXTENDED && rx_byte != SC_BREAK) begin
			key_event.code <= rx_byte;
			key_event.extended <= (state == GOT_E0) || (state == GOT_E0_F0);
			key_event.released <= (state == GOT_F0) || (state == GOT_E0_F0);
		end
	end

	// Pulse and payload both come from the strobed byte
	a_valid_follows_strobe: assert property (@(posedge clk) disable iff (rst)
		key_valid |-> $past(rx_strobe) && (key_event.code == $past(rx_byte)));

endmodule

`default_nettype wire

// ==== rtl/ps2_keyboard_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx import ps2_frame_pkg::*, key_event_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_clk,     // Open-collector keyboard clock pin
	input  logic       ps2_data,    // Open-collector keyboard data pin
	output key_event_t key_event,
	output logic       key_valid,
	output logic       frame_error  // Parity, framing or timeout
);

	logic line_clk;
	logic line_data;
	ps2_byte_t rx_byte;
	logic rx_strobe;
	logic rx_error;

	// Clean up both pins
	ps2_debounce deb_clk (
		.clk      (clk),
		.rst      (rst),
		.line_in  (ps2_clk),
		.line_out (line_clk)
	);

	ps2_debounce deb_data (
		.clk      (clk),
		.rst      (rst),
		.line_in  (ps2_data),
		.line_out (line_data)
	);

	ps2_frame_rx frame_rx0 (
		.clk       (clk),
		.rst       (rst),
		.line_clk  (line_clk),
		.line_data (line_data),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.rx_error  (rx_error)
	);

	ps2_scan_decoder decoder0 (
		.clk       (clk),
		.rst       (rst),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.rx_error  (rx_error),
		.key_event (key_event),
		.key_valid (key_valid)
	);

	assign frame_error = rx_error;

endmodule

`default_nettype wire

// ==== bench/tb_ps2_keyboard_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyboard_rx import ps2_frame_pkg::*, key_event_pkg::*; ();

	localparam int NUM_FRAMES = 75;                    // Upper bound over all tests
	localparam int FRAME_NS = (11 * 80 + 3000) * 10;   // One frame plus its idle gap
	localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_NS * 12 / 10; // 20 percent margin

	logic clk = 1'b0;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	key_event_t key_event;
	logic key_valid;
	logic frame_error;

	key_event_t ev_q[$];      // Events seen at the DUT output
	int err_seen = 0;         // frame_error pulses so far
	int exp_errors = 0;       // Expected running error count
	int fail_count = 0;       // Failed checks
	int tests_passed = 0;
	int tests_failed = 0;
	logic [31:0] rng = 32'hd60c;

	ps2_keyboard_rx dut0 (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.key_event   (key_event),
		.key_valid   (key_valid),
		.frame_error (frame_error)
	);

	always #5 clk = ~clk; // 10 ns period

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (key_valid) ev_q.push_back(key_event);
			if (frame_error) err_seen++;
		end
	end

	// Watchdog against a stuck run
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic key_event_t make_event(input scan_code_t code, input logic ext,
			input logic rel);
		key_event_t e;
		e.code = code;
		e.extended = ext;
		e.released = rel;
		return e;
	endfunction

	// Keyboard model with 80 cycles per bit and data set while the clock is high
	task automatic send_frame(input ps2_byte_t b, input logic bad_parity, input int nbits);
		logic par;
		ps2_frame_t bits;
		par = ~(^b) ^ bad_parity;          // Odd parity unless flipped on purpose
		bits = {1'b1, par, b, 1'b0};        // Stop, parity, data, start
		for (int i = 0; i < nbits; i++) begin
			@(negedge clk) ps2_data = bits[0];
			bits = bits >> 1;
			repeat (20) @(negedge clk);    // Setup before the falling edge
			ps2_clk = 1'b0;
			repeat (40) @(negedge clk);
			ps2_clk = 1'b1;
			repeat (20) @(negedge clk);
		end
		ps2_data = 1'b1;
		repeat (3000) @(negedge clk);      // Longer than the idle timeout
	endtask

	task automatic check_event(input key_event_t exp);
		key_event_t got;
		if (ev_q.size() == 0) begin
			$display("At %0t: expected key event but none was received", $time);
			fail_count++;
		end else begin
			got = ev_q.pop_front();
			if (got !== exp) begin
				$display("ERR %0t: event code %h ext %b rel %b, expected code %h ext %b rel %b",
					$time, got.code, got.extended, got.released,
					exp.code, exp.extended, exp.released);
				fail_count++;
			end
		end
	endtask

	task automatic check_errors(input int exp);
		if (err_seen != exp) begin
			$display("ERR %0t: frame error count %0d, expected %0d", $time, err_seen, exp);
			fail_count++;
		end
	endtask

	task automatic check_no_event();
		if (ev_q.size() != 0) begin
			$display("ERR %0t: %0d unexpected key event(s), first code %h",
				$time, ev_q.size(), ev_q[0].code);
			fail_count++;
			ev_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (fail_count == fails_before) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: %0d check(s) failed", name, fail_count - fails_before);
		end
	endtask

	task automatic test_make_code();
		int f0;
		f0 = fail_count;
		send_frame(8'h1C, 1'b0, 11);
		check_event(make_event(8'h1C, 1'b0, 1'b0));
		check_no_event();
		check_errors(exp_errors);
		report_test("make code", f0);
	endtask

	task automatic test_break_code();
		int f0;
		f0 = fail_count;
		send_frame(8'hF0, 1'b0, 11);
		check_no_event();                  // Prefix alone emits nothing
		send_frame(8'h1C, 1'b0, 11);
		check_event(make_event(8'h1C, 1'b0, 1'b1));
		check_no_event();
		check_errors(exp_errors);
		report_test("break code", f0);
	endtask

	task automatic test_extended();
		int f0;
		f0 = fail_count;
		send_frame(8'hE0, 1'b0, 11);
		send_frame(8'h75, 1'b0, 11);
		check_event(make_event(8'h75, 1'b1, 1'b0));
		send_frame(8'hE0, 1'b0, 11);
		send_frame(8'hF0, 1'b0, 11);
		check_no_event();
		send_frame(8'h75, 1'b0, 11);
		check_event(make_event(8'h75, 1'b1, 1'b1));
		check_no_event();
		check_errors(exp_errors);
		report_test("extended make and break", f0);
	endtask

	task automatic test_parity_error();
		int f0;
		f0 = fail_count;
		send_frame(8'hE0, 1'b0, 11);
		send_frame(8'h1C, 1'b1, 11);       // Bad parity clears the E0
		exp_errors++;
		check_errors(exp_errors);
		check_no_event();
		send_frame(8'h1C, 1'b0, 11);
		check_event(make_event(8'h1C, 1'b0, 1'b0));
		check_no_event();
		report_test("parity error", f0);
	endtask

	task automatic test_truncated();
		int f0;
		f0 = fail_count;
		send_frame(8'h5A, 1'b0, 5);        // Keyboard stops after five bits
		exp_errors++;
		check_errors(exp_errors);
		check_no_event();
		send_frame(8'h5A, 1'b0, 11);
		check_event(make_event(8'h5A, 1'b0, 1'b0));
		check_no_event();
		report_test("truncated frame", f0);
	endtask

	task automatic test_random();
		int f0;
		ps2_byte_t b;
		logic [1:0] sel;                   // Bit 0 E0, bit 1 F0
		f0 = fail_count;
		for (int n = 0; n < 20; n++) begin
			do begin
				rng = xorshift(rng);
				b = rng[7:0];
			end while (b == 8'hE0 || b == 8'hF0);
			rng = xorshift(rng);
			sel = rng[9:8];
			if (sel[0]) send_frame(8'hE0, 1'b0, 11);
			if (sel[1]) send_frame(8'hF0, 1'b0, 11);
			send_frame(b, 1'b0, 11);
			check_event(make_event(b, sel[0], sel[1]));
		end
		check_no_event();
		check_errors(exp_errors);
		report_test("random sequence", f0);
	endtask

	initial begin
		rst = 1'b1;
		ps2_clk = 1'b1;                    // Bus idles high
		ps2_data = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		repeat (40) @(negedge clk);        // Let the debouncers settle
		test_make_code();
		test_break_code();
		test_extended();
		test_parity_error();
		test_truncated();
		test_random();
		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/ps2_frame_pkg.sv
rtl/key_event_pkg.sv
rtl/ps2_debounce.sv
rtl/ps2_frame_rx.sv
rtl/ps2_scan_decoder.sv
rtl/ps2_keyboard_rx.sv
bench/tb_ps2_keyboard_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the PS/2 receiver testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ps2_keyboard_rx -f verilog.f \
	|| { echo "Verilator build failed"; exit 1; }

# Output goes to the terminal and to grep
./obj_dir/Vtb_ps2_keyboard_rx | tee /dev/stderr | grep "Test OK" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
